// File: logic/snake_pkg.sv
package snake_pkg;

	typedef logic [2:0] colour_t;

	localparam colour_t colour_black = 3'b000;
	localparam colour_t colour_snake = 3'b010;	// green.
	localparam colour_t colour_food  = 3'b100;	// red.

	typedef enum logic [1:0] {
		dir_up    = 2'd0,
		dir_down  = 2'd1,
		dir_left  = 2'd2,
		dir_right = 2'd3
	} dir_t;	// bit 0 flips to the opposite direction.

	typedef enum logic [2:0] {
		st_idle,
		st_clear,
		st_init,
		st_wait_tick,
		st_move,
		st_over
	} game_state_t;

	localparam int score_digits = 4;

endpackage

// File: logic/tick_divider.sv
`timescale 1ns/1ps

module tick_divider import snake_pkg::*; #(
	parameter int tick_cycles = 10_000_000,
	parameter int tick_step = 200_000,
	parameter int tick_min = 2_000_000
) (
	input  logic clk,
	input  logic reset_n,
	input  logic run,
	input  logic [4*score_digits-1:0] score,
	output logic tick
);
	logic [31:0] score_bin;
	logic [31:0] step_total;
	logic [31:0] period;
	logic [31:0] count;

	always_comb
	begin
		score_bin = '0;
		for (int i = score_digits - 1; i >= 0; i--)
			score_bin = score_bin * 32'd10 + 32'(score[4*i +: 4]);	// bcd to binary.
		step_total = score_bin * 32'(tick_step);
		if (step_total >= 32'(tick_cycles - tick_min))
			period = 32'(tick_min);	// floor.
		else
			period = 32'(tick_cycles) - step_total;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			count <= 32'(tick_cycles - 1);
			tick <= 1'b0;
		end
		else if (!run)
		begin
			count <= 32'(tick_cycles - 1);
			tick <= 1'b0;
		end
		else if (count == '0)
		begin
			count <= period - 32'd1;	// new rate picked up here.
			tick <= 1'b1;
		end
		else
		begin
			count <= count - 32'd1;
			tick <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (!reset_n) tick |=> !tick)
		else $error("tick held for two cycles, period %0d", period);

endmodule

// File: logic/snake_fsm.sv
`timescale 1ns/1ps

module snake_fsm import snake_pkg::*; (
	input  logic clk,
	input  logic reset_n,
	input  logic start,
	input  logic tick,
	input  logic clear_done,
	input  logic step_done,
	input  logic died,
	output logic clear_req,
	output logic init_body,
	output logic step,
	output logic run,
	output logic playing,
	output logic dead
);
	game_state_t state;
	logic pending;	// one tick caught mid-move.

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= st_idle;
			pending <= 1'b0;
			clear_req <= 1'b0;
			init_body <= 1'b0;
			step <= 1'b0;
		end
		else
		begin
			clear_req <= 1'b0;
			init_body <= 1'b0;
			step <= 1'b0;
			case (state)
				st_idle, st_over:
					if (start)
					begin
						state <= st_clear;
						clear_req <= 1'b1;
					end
				st_clear:
					if (clear_done)
					begin
						state <= st_init;
						init_body <= 1'b1;
					end
				st_init:
				begin
					state <= st_wait_tick;
					pending <= 1'b0;
				end
				st_wait_tick:
					if (tick)
					begin
						state <= st_move;
						step <= 1'b1;
					end
				st_move:
				begin
					if (step_done)
					begin
						pending <= 1'b0;
						if (died)
							state <= st_over;
						else if (pending || tick)
							step <= 1'b1;	// back-to-back move.
						else
							state <= st_wait_tick;
					end
					else if (tick)
						pending <= 1'b1;	// a second one is dropped.
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign run = (state == st_wait_tick) || (state == st_move);
	assign playing = run || (state == st_init);
	assign dead = (state == st_over);

	// no new move until the body reports the previous one finished.
	assert property (@(posedge clk) disable iff (!reset_n) step |=> (!step) until_with step_done)
		else $error("step raised during a move, state %0d", state);

endmodule

// File: logic/snake_body.sv
`timescale 1ns/1ps

module snake_body import snake_pkg::*; #(
	parameter int grid_cols = 160,
	parameter int grid_rows = 120,
	parameter int max_length = 32,
	parameter logic [15:0] lfsr_seed = 16'hace1
) (
	input  logic clk,
	input  logic reset_n,
	input  logic init_body,
	input  logic step,
	input  logic [3:0] dir_buttons,
	output logic [7:0] body_x,
	output logic [6:0] body_y,
	output colour_t body_colour,
	output logic body_plot,
	output logic step_done,
	output logic died,
	output logic ate
);
	localparam int ptr_w = $clog2(max_length);
	localparam int len_w = $clog2(max_length + 1);
	localparam logic [7:0] last_col = 8'(grid_cols - 1);
	localparam logic [6:0] last_row = 7'(grid_rows - 1);
	localparam logic [7:0] mid_x = 8'(grid_cols / 2);
	localparam logic [6:0] mid_y = 7'(grid_rows / 2);

	typedef enum logic [2:0] {p_idle, p_init, p_scan, p_erase, p_head, p_food} phase_t;

	logic [7:0] ring_x [max_length];
	logic [6:0] ring_y [max_length];
	logic [ptr_w-1:0] head_ptr;
	logic [ptr_w-1:0] tail_ptr;
	logic [ptr_w-1:0] scan_ptr;
	logic [len_w-1:0] length;
	logic [len_w-1:0] scan_left;
	phase_t phase;
	dir_t dir;
	dir_t press;
	dir_t dir_sel;
	logic [1:0] init_cnt;
	logic [7:0] next_x, new_x, food_x, rand_x;
	logic [6:0] next_y, new_y, food_y, rand_y;
	logic [15:0] lfsr;
	logic wall;
	logic eat;
	logic grow;
	logic hit;
	logic match;

	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(max_length - 1))
			return '0;
		return p + 1'b1;
	endfunction

	always_comb
	begin
		case (dir_buttons)
			4'b0001: press = dir_up;
			4'b0010: press = dir_down;
			4'b0100: press = dir_left;
			4'b1000: press = dir_right;
			default: press = dir;	// none or several held.
		endcase
		dir_sel = (press == dir_t'(dir ^ 2'b01)) ? dir : press;
		next_x = ring_x[head_ptr];
		next_y = ring_y[head_ptr];
		wall = 1'b0;
		case (dir_sel)
			dir_up:
			begin
				wall = (next_y == 7'd0);
				next_y = next_y - 7'd1;
			end
			dir_down:
			begin
				wall = (next_y == last_row);
				next_y = next_y + 7'd1;
			end
			dir_left:
			begin
				wall = (next_x == 8'd0);
				next_x = next_x - 8'd1;
			end
			default:
			begin
				wall = (next_x == last_col);
				next_x = next_x + 8'd1;
			end
		endcase
	end

	// the tail only blocks the head when it stays put.
	assign match = (ring_x[scan_ptr] == new_x) && (ring_y[scan_ptr] == new_y)
		&& (scan_ptr != tail_ptr || grow);
	assign rand_x = 8'(lfsr[15:8] % grid_cols);
	assign rand_y = 7'(lfsr[7:0] % grid_rows);

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			lfsr <= lfsr_seed;
		else
			lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
	end

	always_ff @(posedge clk)
	begin
		if (init_body)
		begin
			ring_x[0] <= mid_x - 8'd2;
			ring_x[1] <= mid_x - 8'd1;
			ring_x[2] <= mid_x;
			ring_y[0] <= mid_y;
			ring_y[1] <= mid_y;
			ring_y[2] <= mid_y;
		end
		else if (phase == p_head)
		begin
			ring_x[ptr_inc(head_ptr)] <= new_x;
			ring_y[ptr_inc(head_ptr)] <= new_y;
		end
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			phase <= p_idle;
			head_ptr <= '0;
			tail_ptr <= '0;
			scan_ptr <= '0;
			length <= '0;
			scan_left <= '0;
			dir <= dir_right;
			init_cnt <= '0;
			new_x <= '0;
			new_y <= '0;
			food_x <= '0;
			food_y <= '0;
			eat <= 1'b0;
			grow <= 1'b0;
			hit <= 1'b0;
			body_x <= '0;
			body_y <= '0;
			body_colour <= colour_black;
			body_plot <= 1'b0;
			step_done <= 1'b0;
			died <= 1'b0;
			ate <= 1'b0;
		end
		else
		begin
			body_plot <= 1'b0;
			step_done <= 1'b0;
			died <= 1'b0;
			ate <= 1'b0;
			if (init_body)
			begin
				head_ptr <= ptr_w'(2);
				tail_ptr <= '0;
				length <= len_w'(3);
				dir <= dir_right;
				food_x <= rand_x;
				food_y <= rand_y;
				init_cnt <= '0;
				phase <= p_init;
			end
			else
			begin
				case (phase)
					p_idle:
						if (step)
						begin
							dir <= dir_sel;	// direction locked here.
							new_x <= next_x;
							new_y <= next_y;
							hit <= wall;
							eat <= (next_x == food_x) && (next_y == food_y);
							grow <= (next_x == food_x) && (next_y == food_y)
								&& (length < len_w'(max_length));
							scan_ptr <= tail_ptr;
							scan_left <= length;
							phase <= p_scan;
						end
					p_init:
					begin
						body_plot <= 1'b1;
						init_cnt <= init_cnt + 2'd1;
						if (init_cnt == 2'd3)
						begin
							body_x <= food_x;
							body_y <= food_y;
							body_colour <= colour_food;
							phase <= p_idle;
						end
						else
						begin
							body_x <= ring_x[ptr_w'(2'd2 - init_cnt)];	// head first.
							body_y <= ring_y[ptr_w'(2'd2 - init_cnt)];
							body_colour <= colour_snake;
						end
					end
					p_scan:
					begin
						hit <= hit | match;
						scan_ptr <= ptr_inc(scan_ptr);
						scan_left <= scan_left - 1'b1;
						if (scan_left == len_w'(1))
						begin
							if (hit || match)
							begin
								step_done <= 1'b1;
								died <= 1'b1;
								phase <= p_idle;
							end
							else
								phase <= grow ? p_head : p_erase;
						end
					end
					p_erase:
					begin
						body_x <= ring_x[tail_ptr];
						body_y <= ring_y[tail_ptr];
						body_colour <= colour_black;
						body_plot <= 1'b1;
						tail_ptr <= ptr_inc(tail_ptr);
						phase <= p_head;
					end
					p_head:
					begin
						body_x <= new_x;
						body_y <= new_y;
						body_colour <= colour_snake;
						body_plot <= 1'b1;
						head_ptr <= ptr_inc(head_ptr);
						if (grow)
							length <= length + 1'b1;
						if (eat)
							phase <= p_food;
						else
						begin
							step_done <= 1'b1;
							phase <= p_idle;
						end
					end
					default:
					begin
						food_x <= rand_x;
						food_y <= rand_y;
						body_x <= rand_x;
						body_y <= rand_y;
						body_colour <= colour_food;
						body_plot <= 1'b1;
						step_done <= 1'b1;
						ate <= 1'b1;
						phase <= p_idle;
					end
				endcase
			end
		end
	end

	assert property (@(posedge clk) disable iff (!reset_n)
		body_plot |-> (body_x <= last_col) && (body_y <= last_row))
		else $error("plot off grid at x %h y %h", body_x, body_y);

endmodule

// File: logic/frame_writer.sv
`timescale 1ns/1ps

module frame_writer import snake_pkg::*; #(
	parameter int grid_cols = 160,
	parameter int grid_rows = 120
) (
	input  logic clk,
	input  logic reset_n,
	input  logic clear_req,
	input  logic [7:0] body_x,
	input  logic [6:0] body_y,
	input  colour_t body_colour,
	input  logic body_plot,
	output logic [7:0] x,
	output logic [6:0] y,
	output colour_t colour,
	output logic plot,
	output logic clear_done
);
	localparam logic [7:0] last_col = 8'(grid_cols - 1);
	localparam logic [6:0] last_row = 7'(grid_rows - 1);

	logic sweeping;
	logic last_pix;
	logic [7:0] sx;
	logic [6:0] sy;
	logic [7:0] cur_x;
	logic [6:0] cur_y;

	assign cur_x = clear_req ? 8'd0 : sx;	// a request restarts at the corner.
	assign cur_y = clear_req ? 7'd0 : sy;
	assign last_pix = (cur_x == last_col) && (cur_y == last_row);

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			sweeping <= 1'b0;
			sx <= '0;
			sy <= '0;
			x <= '0;
			y <= '0;
			colour <= colour_black;
			plot <= 1'b0;
			clear_done <= 1'b0;
		end
		else if (clear_req || sweeping)
		begin
			x <= cur_x;
			y <= cur_y;
			colour <= colour_black;
			plot <= 1'b1;
			sx <= (cur_x == last_col) ? 8'd0 : cur_x + 8'd1;
			sy <= (cur_x == last_col) ? cur_y + 7'd1 : cur_y;
			sweeping <= !last_pix;
			clear_done <= last_pix;
		end
		else
		begin
			x <= body_x;
			y <= body_y;
			colour <= body_colour;
			plot <= body_plot;
			clear_done <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (!reset_n) sweeping |-> !body_plot)
		else $error("body plot at x %h y %h during clear", body_x, body_y);

endmodule

// File: logic/score_keeper.sv
`timescale 1ns/1ps

module score_keeper import snake_pkg::*; (
	input  logic clk,
	input  logic reset_n,
	input  logic init_body,
	input  logic ate,
	input  logic died,
	output logic [4*score_digits-1:0] score,
	output logic [4*score_digits-1:0] high_score
);
	localparam logic [4*score_digits-1:0] score_max = {score_digits{4'h9}};

	logic [4*score_digits-1:0] score_inc;
	logic carry;

	always_comb
	begin
		score_inc = score;
		carry = 1'b1;
		for (int i = 0; i < score_digits; i++)
		begin
			if (carry)
			begin
				if (score[4*i +: 4] == 4'd9)
					score_inc[4*i +: 4] = 4'd0;	// ripple on.
				else
				begin
					score_inc[4*i +: 4] = score[4*i +: 4] + 4'd1;
					carry = 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			score <= '0;
			high_score <= '0;
		end
		else
		begin
			if (init_body)
				score <= '0;
			else if (ate && score != score_max)
				score <= score_inc;
			// digits most significant first, so a plain compare orders bcd.
			if (died && score > high_score)
				high_score <= score;
		end
	end

	for (genvar i = 0; i < score_digits; i++)
	begin : g_digit_chk
		assert property (@(posedge clk) disable iff (!reset_n) score[4*i +: 4] <= 4'd9)
			else $error("score digit %0d not bcd, score %h", i, score);
	end

endmodule

// File: logic/snake_game.sv
`timescale 1ns/1ps

module snake_game import snake_pkg::*; #(
	parameter int grid_cols = 160,
	parameter int grid_rows = 120,
	parameter int max_length = 32,
	parameter int tick_cycles = 10_000_000,
	parameter int tick_step = 200_000,
	parameter int tick_min = 2_000_000,
	parameter logic [15:0] lfsr_seed = 16'hace1
) (
	input  logic clk,
	input  logic reset_n,
	input  logic start,
	input  logic [3:0] dir_buttons,
	output logic [7:0] x,
	output logic [6:0] y,
	output colour_t colour,
	output logic plot,
	output logic [4*score_digits-1:0] score,
	output logic [4*score_digits-1:0] high_score,
	output logic dead,
	output logic playing
);
	logic tick;
	logic run;
	logic clear_req;
	logic clear_done;
	logic init_body;
	logic step;
	logic step_done;
	logic died;
	logic ate;
	logic [7:0] body_x;
	logic [6:0] body_y;
	colour_t body_colour;
	logic body_plot;

	tick_divider #(.tick_cycles(tick_cycles), .tick_step(tick_step), .tick_min(tick_min))
		u_tick (.clk, .reset_n, .run, .score, .tick);

	snake_fsm u_fsm (.clk, .reset_n, .start, .tick, .clear_done, .step_done, .died,
		.clear_req, .init_body, .step, .run, .playing, .dead);

	snake_body #(.grid_cols(grid_cols), .grid_rows(grid_rows), .max_length(max_length),
		.lfsr_seed(lfsr_seed))
		u_body (.clk, .reset_n, .init_body, .step, .dir_buttons, .body_x, .body_y,
			.body_colour, .body_plot, .step_done, .died, .ate);

	frame_writer #(.grid_cols(grid_cols), .grid_rows(grid_rows))
		u_writer (.clk, .reset_n, .clear_req, .body_x, .body_y, .body_colour, .body_plot,
			.x, .y, .colour, .plot, .clear_done);

	score_keeper u_score (.clk, .reset_n, .init_body, .ate, .died, .score, .high_score);

endmodule

// File: dv/snake_game_tb.sv
`timescale 1ns/1ps

module snake_game_tb import snake_pkg::*;
();
	localparam int cols = 16;
	localparam int rows = 8;
	localparam int t_cycles = 300;
	localparam int t_step = 20;
	localparam int t_min = 100;
	localparam int timeout_cycles = 60000;	// 3 games, clear plus 40 moves of 400, rounded up.
	localparam logic [1:0] ph_idle = 2'd0;
	localparam logic [1:0] ph_clear = 2'd1;
	localparam logic [1:0] ph_init = 2'd2;
	localparam logic [1:0] ph_play = 2'd3;

	logic clk = 1'b0;
	logic reset_n = 1'b0;
	logic start = 1'b0;
	logic [3:0] dir_buttons = 4'b0000;
	logic [7:0] x;
	logic [6:0] y;
	colour_t colour;
	logic plot;
	logic [15:0] score;
	logic [15:0] high_score;
	logic dead;
	logic playing;

	integer seed = 32'hd9ef_22d1;
	int cyc = 0;
	logic [1:0] phase = ph_idle;
	int clr_idx = 0;
	int init_cnt = 0;
	int head_x = 0;
	int head_y = 0;
	int food_x = 0;
	int food_y = 0;
	int exp_dx = 1;
	int exp_dy = 0;
	int heads = 0;
	logic erased = 1'b0;
	logic [15:0] exp_score = '0;
	logic [15:0] prev_high = '0;
	logic [15:0] last_score = '0;
	int last_entry = 0;
	logic have_prev = 1'b0;
	logic was_move = 1'b0;
	logic dead_q = 1'b0;
	logic [1:0] acc_q = 2'b00;
	logic ready;
	logic in_move;
	logic at_food;
	logic press_valid;
	int press_dx;
	int press_dy;
	int gap;
	int exp_gap;
	logic [15:0] high_expect;

	snake_game #(.grid_cols(cols), .grid_rows(rows), .tick_cycles(t_cycles),
		.tick_step(t_step), .tick_min(t_min))
		u_dut (.clk, .reset_n, .start, .dir_buttons, .x, .y, .colour, .plot, .score,
			.high_score, .dead, .playing);

	always #20 clk = ~clk;

	function automatic int bcd_to_int(input logic [15:0] v);
		int n;
		n = 0;
		for (int i = 3; i >= 0; i--)
			n = n * 10 + int'(v[4*i +: 4]);
		return n;
	endfunction

	function automatic logic [15:0] int_to_bcd(input int n);
		logic [15:0] v;
		for (int i = 0; i < 4; i++)
		begin
			v[4*i +: 4] = 4'(n % 10);
			n = n / 10;
		end
		return v;
	endfunction

	function automatic logic [3:0] toward_food();
		int ddx;
		int ddy;
		ddx = food_x - head_x;
		ddy = food_y - head_y;
		if (ddx > 0 && exp_dx != -1)
			return 4'b1000;
		if (ddx < 0 && exp_dx != 1)
			return 4'b0100;
		if (ddy > 0 && exp_dy != -1)
			return 4'b0010;
		if (ddy < 0 && exp_dy != 1)
			return 4'b0001;
		// food behind the head, turn toward the roomier half.
		if (exp_dx != 0)
			return (head_y < rows / 2) ? 4'b0010 : 4'b0001;
		return (head_x < cols / 2) ? 4'b1000 : 4'b0100;
	endfunction

	task automatic fail_now();
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	assign ready = (u_dut.u_fsm.state == st_idle) || (u_dut.u_fsm.state == st_over);
	assign in_move = (u_dut.u_fsm.state == st_move);
	assign at_food = (int'(x) == food_x) && (int'(y) == food_y);
	assign gap = cyc - last_entry;
	assign high_expect = (bcd_to_int(exp_score) > bcd_to_int(prev_high)) ? exp_score : prev_high;

	always_comb
	begin
		press_valid = 1'b1;
		press_dx = 0;
		press_dy = 0;
		case (dir_buttons)
			4'b0001: press_dy = -1;
			4'b0010: press_dy = 1;
			4'b0100: press_dx = -1;
			4'b1000: press_dx = 1;
			default: press_valid = 1'b0;
		endcase
		exp_gap = t_cycles - t_step * bcd_to_int(last_score);
		if (exp_gap < t_min)
			exp_gap = t_min;
	end

	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (cyc > timeout_cycles)
		begin
			$display("timeout, the games did not finish within %0d cycles", timeout_cycles);
			fail_now();
		end
	end

	// reference model of the plot stream.
	always @(posedge clk)
	begin
		dead_q <= dead;
		acc_q <= {acc_q[0], start && ready};
		was_move <= in_move;
		if (u_dut.step && press_valid && !(press_dx == -exp_dx && press_dy == -exp_dy))
		begin
			exp_dx <= press_dx;
			exp_dy <= press_dy;
		end
		if (start && ready)
		begin
			phase <= ph_clear;
			clr_idx <= 0;
			init_cnt <= 0;
			exp_dx <= 1;
			exp_dy <= 0;
			have_prev <= 1'b0;
			exp_score <= '0;
		end
		else if (plot)
		begin
			case (phase)
				ph_clear:
				begin
					clr_idx <= clr_idx + 1;
					if (clr_idx == cols * rows - 1)
						phase <= ph_init;
				end
				ph_init:
					if (colour == colour_snake)
					begin
						if (init_cnt == 0)
						begin
							head_x <= int'(x);
							head_y <= int'(y);
						end
						init_cnt <= init_cnt + 1;
					end
					else
					begin
						food_x <= int'(x);
						food_y <= int'(y);
						erased <= 1'b0;
						phase <= ph_play;
					end
				ph_play:
					if (colour == colour_black)
						erased <= 1'b1;
					else if (colour == colour_snake)
					begin
						head_x <= int'(x);
						head_y <= int'(y);
						erased <= 1'b0;
						heads <= heads + 1;
						if (at_food)
							exp_score <= int_to_bcd(bcd_to_int(exp_score) + 1);
					end
					else
					begin
						food_x <= int'(x);
						food_y <= int'(y);
					end
				default: ;
			endcase
		end
		if (in_move && !was_move)
		begin
			have_prev <= 1'b1;
			last_entry <= cyc;
			last_score <= exp_score;
		end
		if (dead && !dead_q)
			prev_high <= high_expect;
	end

	a_idle_quiet: assert property (@(posedge clk) disable iff (!reset_n)
		phase == ph_idle |-> !plot && !dead && !playing)
		else
		begin
			$display("[ERROR] after reset plot %h dead %h playing %h", plot, dead, playing);
			fail_now();
		end

	a_playing: assert property (@(posedge clk) disable iff (!reset_n)
		phase == ph_play |-> playing == !dead)
		else
		begin
			$display("[ERROR] playing %h, expected %h", playing, !dead);
			fail_now();
		end

	a_start_lat: assert property (@(posedge clk) disable iff (!reset_n)
		acc_q[1] |-> plot && x == 8'd0 && y == 7'd0 && colour == colour_black)
		else
		begin
			$display("[ERROR] first clear plot %h x %h y %h colour %h", plot, x, y, colour);
			fail_now();
		end

	a_clear_order: assert property (@(posedge clk) disable iff (!reset_n)
		plot && phase == ph_clear |->
			colour == colour_black && int'(x) == clr_idx % cols && int'(y) == clr_idx / cols)
		else
		begin
			$display("[ERROR] clear plot x %h y %h colour %h, expected x %h y %h colour %h",
				x, y, colour, clr_idx % cols, clr_idx / cols, colour_black);
			fail_now();
		end

	a_init_draw: assert property (@(posedge clk) disable iff (!reset_n)
		plot && phase == ph_init |-> colour != colour_black
			&& (colour != colour_food || init_cnt == 3)
			&& (colour != colour_snake || init_cnt != 0
				|| (x == 8'(cols / 2) && y == 7'(rows / 2))))
		else
		begin
			$display("[ERROR] init plot x %h y %h colour %h, snake cells so far %h",
				x, y, colour, init_cnt);
			fail_now();
		end

	a_head_step: assert property (@(posedge clk) disable iff (!reset_n)
		plot && phase == ph_play && colour == colour_snake |->
			int'(x) == head_x + exp_dx && int'(y) == head_y + exp_dy)
		else
		begin
			$display("[ERROR] head x %h y %h, expected x %h y %h",
				x, y, head_x + exp_dx, head_y + exp_dy);
			fail_now();
		end

	a_erase_order: assert property (@(posedge clk) disable iff (!reset_n)
		plot && phase == ph_play && colour == colour_snake |-> (at_food ? !erased : erased))
		else
		begin
			$display("[ERROR] erased %h before head x %h y %h, food x %h y %h",
				erased, x, y, food_x, food_y);
			fail_now();
		end

	a_score_inc: assert property (@(posedge clk) disable iff (!reset_n)
		plot && (phase == ph_init || phase == ph_play) |-> score == exp_score)
		else
		begin
			$display("[ERROR] score %h, expected %h", score, exp_score);
			fail_now();
		end

	a_dead_quiet: assert property (@(posedge clk) disable iff (!reset_n) dead |-> !plot)
		else
		begin
			$display("[ERROR] plot %h while dead, x %h y %h", plot, x, y);
			fail_now();
		end

	a_high_score: assert property (@(posedge clk) disable iff (!reset_n)
		dead && !dead_q |-> high_score == high_expect)
		else
		begin
			$display("[ERROR] high_score %h, expected %h", high_score, high_expect);
			fail_now();
		end

	a_tick_gap: assert property (@(posedge clk) disable iff (!reset_n)
		in_move && !was_move && have_prev |-> gap == exp_gap)
		else
		begin
			$display("[ERROR] tick gap %h, expected %h at score %h", gap, exp_gap, last_score);
			fail_now();
		end

	task automatic play_game(input int steer_moves);
		int seen;
		int n;
		int r;
		@(posedge clk);
		#2 start = 1'b1;
		@(posedge clk);
		#2 start = 1'b0;
		while (phase != ph_play)
			@(posedge clk);
		n = 0;
		while (!dead && n < steer_moves)
		begin
			seen = heads;
			while (heads == seen && !dead)
				@(posedge clk);
			#2;
			r = $random(seed);
			if (r[2:0] == 3'd0)
				dir_buttons = r[7:4];	// none, several or reverse now and then.
			else
				dir_buttons = toward_food();
			n++;
		end
		@(posedge clk);
		#2 dir_buttons = (exp_dy == 1) ? 4'b0010 : 4'b0001;	// straight at a wall.
		while (!dead)
			@(posedge clk);
		repeat (20) @(posedge clk);
	endtask

	initial
	begin
		repeat (16) @(posedge clk);
		#2 reset_n = 1'b1;
		play_game(24);
		play_game(6);
		play_game(24);
		$display("** PASS **");
		$finish;
	end

endmodule

// File: snake_game.f
logic/snake_pkg.sv
logic/tick_divider.sv
logic/snake_fsm.sv
logic/snake_body.sv
logic/frame_writer.sv
logic/score_keeper.sv
logic/snake_game.sv
dv/snake_game_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= snake_game_tb
FILELIST  ?= snake_game.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
